// File: common/burst_if.sv
interface burst_if #(
	parameter int INDEX_W = 7
);

	localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
		- dcache_pkg::BYTE_OFF_W;

	// one-cycle requests from the controller
	logic fill_start;
	logic evict_start;

	// tag and index of the line to move
	logic [TAG_W+INDEX_W-1:0] line_addr;

	// victim word for the beat at beat_offset
	dcache_pkg::word_t evict_data;

	// refill beats as they arrive
	dcache_pkg::word_t fill_data;
	logic fill_beat;
	dcache_pkg::offset_t beat_offset;

	logic evict_done;
	logic fill_done;

	modport ctrl (
		output fill_start, evict_start, line_addr, evict_data,
		input fill_data, fill_beat, beat_offset, evict_done, fill_done
	);

	modport master (
		input fill_start, evict_start, line_addr, evict_data,
		output fill_data, fill_beat, beat_offset, evict_done, fill_done
	);

endinterface

// File: common/dcache_pkg.sv
package dcache_pkg;

	// byte address and data word of the CPU
	parameter int ADDR_W = 32;
	parameter int WORD_W = 32;

	// line geometry, one burst beat per word
	parameter int LINE_WORDS = 16;
	parameter int OFFSET_W = 4;
	parameter int BYTE_OFF_W = 2;

	// one data word
	typedef logic [WORD_W-1:0] word_t;

	// one enable per byte lane
	typedef logic [WORD_W/8-1:0] byte_en_t;

	// word index inside a line, also the beat number of a burst
	typedef logic [OFFSET_W-1:0] offset_t;

endpackage

// File: common/way_port_if.sv
interface way_port_if #(
	parameter int INDEX_W = 7
);

	localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
		- dcache_pkg::BYTE_OFF_W;

	// set and word select, shared by reads and writes
	logic [INDEX_W-1:0] index;
	dcache_pkg::offset_t offset;

	// write side
	logic we;
	logic [TAG_W-1:0] wr_tag;
	dcache_pkg::word_t wr_data;
	dcache_pkg::byte_en_t byte_en;
	logic wr_dirty;
	logic wr_valid;

	// read side, data word one clock behind index and offset
	logic [TAG_W-1:0] rd_tag;
	logic rd_valid;
	logic rd_dirty;
	dcache_pkg::word_t rd_data;

	modport ctrl (
		output index, offset, we, wr_tag, wr_data, byte_en, wr_dirty, wr_valid,
		input rd_tag, rd_valid, rd_dirty, rd_data
	);

	modport way (
		input index, offset, we, wr_tag, wr_data, byte_en, wr_dirty, wr_valid,
		output rd_tag, rd_valid, rd_dirty, rd_data
	);

endinterface

// File: compile.f
common/dcache_pkg.sv
common/way_port_if.sv
common/burst_if.sv
dcache/cache_way.sv
dcache/dcache_ctrl.sv
verilog/axi_burst_master.sv
verilog/dcache_top.sv
verification/dcache_tb.sv

// File: dcache/cache_way.sv
module cache_way #(
	parameter int INDEX_W = 7
) (
	input logic clk,
	input logic rst_n,
	way_port_if.way port
);

	localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
		- dcache_pkg::BYTE_OFF_W;
	localparam int SETS = 1 << INDEX_W;
	localparam int BYTES = dcache_pkg::WORD_W / 8;

	logic [TAG_W-1:0] tag_mem [SETS];
	logic [SETS-1:0] valid_bits;
	logic [SETS-1:0] dirty_bits;
	dcache_pkg::word_t data_mem [SETS * dcache_pkg::LINE_WORDS];
	logic [INDEX_W+dcache_pkg::OFFSET_W-1:0] word_addr;

	assign word_addr = {port.index, port.offset};

	// set status is seen in the request cycle for the hit check
	assign port.rd_tag = tag_mem[port.index];
	assign port.rd_valid = valid_bits[port.index];
	assign port.rd_dirty = dirty_bits[port.index];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			valid_bits <= '0;
		else if (port.we)
			valid_bits[port.index] <= port.wr_valid;
	end

	// dirty only counts together with valid
	always_ff @(posedge clk)
	begin
		if (port.we)
		begin
			tag_mem[port.index] <= port.wr_tag;
			dirty_bits[port.index] <= port.wr_dirty;
		end
	end

	// byte lane merge, read port returns the word before the write
	always_ff @(posedge clk)
	begin
		for (int b = 0; b < BYTES; b++)
		begin
			if (port.we && port.byte_en[b])
				data_mem[word_addr][b*8 +: 8] <= port.wr_data[b*8 +: 8];
		end
		port.rd_data <= data_mem[word_addr];
	end

	// partial writes only ever land in a line that already holds data
	assert property (@(posedge clk) disable iff (!rst_n)
		port.we && port.wr_valid |-> port.byte_en == '1 || port.rd_valid);

endmodule

// File: dcache/dcache_ctrl.sv
module dcache_ctrl #(
	parameter int INDEX_W = 7
) (
	input logic clk,
	input logic rst_n,
	input logic cpu_re,
	input logic cpu_we,
	input logic [dcache_pkg::ADDR_W-1:0] cpu_addr,
	input dcache_pkg::word_t cpu_wdata,
	input dcache_pkg::byte_en_t cpu_byte_en,
	output dcache_pkg::word_t cpu_rdata,
	output logic stall,
	way_port_if.ctrl way0,
	way_port_if.ctrl way1,
	burst_if.ctrl bus
);

	localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
		- dcache_pkg::BYTE_OFF_W;
	localparam int SETS = 1 << INDEX_W;
	localparam dcache_pkg::offset_t LAST_BEAT = dcache_pkg::offset_t'(dcache_pkg::LINE_WORDS - 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_EVICT,
		S_WAIT_BRESP,
		S_FILL,
		S_INSTALL
	} state_t;

	state_t state;

	logic [TAG_W-1:0] cpu_tag;
	logic [INDEX_W-1:0] cpu_index;
	dcache_pkg::offset_t cpu_offset;

	// lru bit names the way to replace next
	logic [SETS-1:0] lru;
	logic hit0;
	logic hit1;
	logic req;
	logic miss;
	logic accept;
	logic victim;
	logic victim_dirty;
	logic [TAG_W-1:0] victim_tag;
	logic rd_way;
	logic fill_we;

	dcache_pkg::offset_t way_offset;
	dcache_pkg::word_t way_wdata;
	dcache_pkg::byte_en_t way_byte_en;
	logic way_valid;

	assign cpu_tag = cpu_addr[dcache_pkg::ADDR_W-1 -: TAG_W];
	assign cpu_index = cpu_addr[dcache_pkg::BYTE_OFF_W+dcache_pkg::OFFSET_W +: INDEX_W];
	assign cpu_offset = cpu_addr[dcache_pkg::BYTE_OFF_W +: dcache_pkg::OFFSET_W];

	assign hit0 = way0.rd_valid && (way0.rd_tag == cpu_tag);
	assign hit1 = way1.rd_valid && (way1.rd_tag == cpu_tag);

	assign req = cpu_re || cpu_we;
	assign miss = req && !(hit0 || hit1);
	assign stall = (state != S_IDLE) || miss;
	assign accept = req && !stall;

	assign victim = lru[cpu_index];
	assign victim_tag = victim ? way1.rd_tag : way0.rd_tag;
	assign victim_dirty = victim ? (way1.rd_valid && way1.rd_dirty)
		: (way0.rd_valid && way0.rd_dirty);

	// a clean victim is simply overwritten by the refill
	assign bus.evict_start = (state == S_IDLE) && miss && victim_dirty;
	assign bus.fill_start = ((state == S_IDLE) && miss && !victim_dirty)
		|| ((state == S_WAIT_BRESP) && bus.evict_done);
	assign bus.line_addr = bus.evict_start ? {victim_tag, cpu_index} : {cpu_tag, cpu_index};
	assign bus.evict_data = victim ? way1.rd_data : way0.rd_data;

	assign cpu_rdata = rd_way ? way1.rd_data : way0.rd_data;

	// ways follow the CPU in idle and the burst beat otherwise
	assign way_offset = (state == S_IDLE) ? cpu_offset : bus.beat_offset;
	assign fill_we = (state == S_FILL) && bus.fill_beat;
	assign way_wdata = fill_we ? bus.fill_data : cpu_wdata;
	assign way_byte_en = fill_we ? '1 : cpu_byte_en;
	assign way_valid = fill_we ? bus.fill_done : 1'b1;

	assign way0.index = cpu_index;
	assign way0.offset = way_offset;
	assign way0.we = (accept && cpu_we && hit0) || (fill_we && !victim);
	assign way0.wr_tag = cpu_tag;
	assign way0.wr_data = way_wdata;
	assign way0.byte_en = way_byte_en;
	assign way0.wr_dirty = !fill_we;
	assign way0.wr_valid = way_valid;

	assign way1.index = cpu_index;
	assign way1.offset = way_offset;
	assign way1.we = (accept && cpu_we && hit1) || (fill_we && victim);
	assign way1.wr_tag = cpu_tag;
	assign way1.wr_data = way_wdata;
	assign way1.byte_en = way_byte_en;
	assign way1.wr_dirty = !fill_we;
	assign way1.wr_valid = way_valid;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= S_IDLE;
			lru <= '0;
			rd_way <= 1'b0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (accept)
					begin
						// the other way becomes the victim
						lru[cpu_index] <= hit0;
						rd_way <= hit1;
					end
					else if (bus.evict_start)
						state <= S_EVICT;
					else if (bus.fill_start)
						state <= S_FILL;
				end
				S_EVICT:
				begin
					if (bus.beat_offset == LAST_BEAT)
						state <= S_WAIT_BRESP;
				end
				S_WAIT_BRESP:
				begin
					if (bus.evict_done)
						state <= S_FILL;
				end
				S_FILL:
				begin
					if (bus.fill_done)
						state <= S_INSTALL;
				end
				S_INSTALL:
				begin
					lru[cpu_index] <= !victim;
					state <= S_IDLE;
				end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	// the held request must not move while its miss is served
	assert property (@(posedge clk) disable iff (!rst_n)
		state != S_IDLE |-> stall && $stable(cpu_addr));

endmodule

// File: verification/dcache_cases.txt
# op  byte address  write data  byte enables  expected read data (hex)
# write lines carry 00000000 as expected value, it is not checked
R 00001040 00000000 0 C0DE1040
R 0000104C 00000000 0 C0DE104C
W 00001048 11223344 5 00000000
R 00001048 00000000 0 C0221044
W 00001040 AABBCCDD 8 00000000
R 00001040 00000000 0 AADE1040
R 00001044 00000000 0 C0DE1044
R 00000400 00000000 0 C0DE0400
R 00002404 00000000 0 C0DE2404
R 00000408 00000000 0 C0DE0408
R 0000440C 00000000 0 C0DE440C
R 00000410 00000000 0 C0DE0410
R 00002414 00000000 0 C0DE2414
W 00000804 DEADBEEF F 00000000
R 00000804 00000000 0 DEADBEEF
W 0000283C 12345678 3 00000000
R 00004800 00000000 0 C0DE4800
R 00006800 00000000 0 C0DE6800
R 00000804 00000000 0 DEADBEEF
R 0000283C 00000000 0 C0DE5678
R 00000800 00000000 0 C0DE0800
R 00003040 00000000 0 C0DE3040
R 00005040 00000000 0 C0DE5040
R 00001048 00000000 0 C0221044
R 00001040 00000000 0 AADE1040
R FFFFF07C 00000000 0 3F21F07C
R 00001040 00000000 0 AADE1040

// File: verification/dcache_tb.sv
module dcache_tb;

	localparam int INDEX_W = 7;
	localparam int LINE_SHIFT = dcache_pkg::OFFSET_W + dcache_pkg::BYTE_OFF_W;
	localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - LINE_SHIFT;
	localparam int SETS = 1 << INDEX_W;
	localparam int BEATS = dcache_pkg::LINE_WORDS;
	localparam int CYCLES_PER_CASE = 400;

	logic clk = 1'b0;
	logic rst_n;
	logic cpu_re;
	logic cpu_we;
	logic [dcache_pkg::ADDR_W-1:0] cpu_addr;
	dcache_pkg::word_t cpu_wdata;
	dcache_pkg::byte_en_t cpu_byte_en;
	dcache_pkg::word_t cpu_rdata;
	logic stall;
	logic [dcache_pkg::ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	dcache_pkg::word_t rdata;
	logic rlast;
	logic rvalid;
	logic rready;
	logic [dcache_pkg::ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	dcache_pkg::word_t wdata;
	logic wlast;
	logic wvalid;
	logic wready;
	logic bvalid;
	logic bready;

	// holds only the words written back by the cache
	dcache_pkg::word_t mem_model [logic [31:0]];
	int read_bursts = 0;
	int write_bursts = 0;
	int error_count = 0;
	int cycle_limit = 0;
	int cycle_count;
	logic [31:0] cur_addr = '0;

	// expected tag state for predicting misses and write-backs
	bit [TAG_W-1:0] ref_tag [SETS][2];
	bit ref_valid [SETS][2];
	bit ref_dirty [SETS][2];
	bit ref_lru [SETS];

	dcache_top #(.INDEX_W(INDEX_W)) uut (.*);

	always #5 clk = ~clk;

	function automatic dcache_pkg::word_t mem_word(input logic [31:0] a);
		if (mem_model.exists(a))
			return mem_model[a];
		return a ^ 32'hC0DE0000;
	endfunction

	task automatic ready_delay();
		repeat ($urandom % 4)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic predict(input logic [31:0] a, input logic wr, output int fills,
		output int evicts);
		int idx;
		int way;
		logic [TAG_W-1:0] tg;
		idx = a[LINE_SHIFT +: INDEX_W];
		tg = a[31 -: TAG_W];
		fills = 0;
		evicts = 0;
		if (ref_valid[idx][0] && ref_tag[idx][0] == tg)
			way = 0;
		else if (ref_valid[idx][1] && ref_tag[idx][1] == tg)
			way = 1;
		else
		begin
			// lru bit names the way that takes the refill
			way = ref_lru[idx];
			fills = 1;
			evicts = ref_valid[idx][way] && ref_dirty[idx][way];
			ref_valid[idx][way] = 1'b1;
			ref_tag[idx][way] = tg;
			ref_dirty[idx][way] = 1'b0;
		end
		if (wr)
			ref_dirty[idx][way] = 1'b1;
		ref_lru[idx] = (way == 0);
	endtask

	task automatic serve_read();
		logic [31:0] base;
		logic taken;
		base = araddr;
		read_bursts++;
		assert (base == (cur_addr >> LINE_SHIFT) << LINE_SHIFT)
		else
		begin
			$display("[ERROR] araddr got %h expected %h", base,
				(cur_addr >> LINE_SHIFT) << LINE_SHIFT);
			error_count++;
		end
		ready_delay();
		arready = 1'b1;
		@(posedge clk);
		#1;
		arready = 1'b0;
		for (int i = 0; i < BEATS; i++)
		begin
			ready_delay();
			rvalid = 1'b1;
			rdata = mem_word(base + 4 * i);
			rlast = (i == BEATS - 1);
			// rready is registered so the edge sees its present value
			do
			begin
				taken = rready;
				@(posedge clk);
				#1;
			end while (!taken);
			rvalid = 1'b0;
			rlast = 1'b0;
		end
		assert (!rready)
		else
		begin
			$display("read burst: rready still high after the last beat");
			error_count++;
		end
	endtask

	task automatic serve_write();
		logic [31:0] base;
		logic taken;
		base = awaddr;
		write_bursts++;
		assert (base[LINE_SHIFT-1:0] == '0
			&& base[LINE_SHIFT +: INDEX_W] == cur_addr[LINE_SHIFT +: INDEX_W])
		else
		begin
			$display("[ERROR] awaddr got %h, not a line base in set %h", base,
				cur_addr[LINE_SHIFT +: INDEX_W]);
			error_count++;
		end
		ready_delay();
		awready = 1'b1;
		@(posedge clk);
		#1;
		awready = 1'b0;
		for (int i = 0; i < BEATS; i++)
		begin
			while (!wvalid)
			begin
				@(posedge clk);
				#1;
			end
			ready_delay();
			assert (wlast == (i == BEATS - 1))
			else
			begin
				$display("[ERROR] wlast got %h expected %h on beat %0d", wlast,
					i == BEATS - 1, i);
				error_count++;
			end
			mem_model[base + 4 * i] = wdata;
			wready = 1'b1;
			@(posedge clk);
			#1;
			wready = 1'b0;
		end
		ready_delay();
		bvalid = 1'b1;
		do
		begin
			taken = bready;
			@(posedge clk);
			#1;
		end while (!taken);
		bvalid = 1'b0;
	endtask

	// memory model serving one burst at a time
	initial
	begin
		int unsigned seed;

		seed = 32'he82d6527;
		void'($urandom(seed));
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rdata = '0;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			if (arvalid === 1'b1)
				serve_read();
			else if (awvalid === 1'b1)
				serve_write();
		end
	end

	initial
	begin
		wait (cycle_limit > 0);
		for (cycle_count = 0; cycle_count < cycle_limit; cycle_count++)
			@(posedge clk);
		$display("timeout: run still busy after %0d cycles", cycle_limit);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		int fd;
		int n;
		int fails;
		int passes;
		int fills;
		int evicts;
		int reads_before;
		int writes_before;
		int errors_before;
		string line;
		logic [7:0] op;
		logic [31:0] a;
		logic [31:0] wd;
		logic [31:0] exp;
		logic [3:0] be;
		logic [7:0] op_q [$];
		logic [31:0] addr_q [$];
		logic [31:0] wdata_q [$];
		logic [3:0] be_q [$];
		logic [31:0] exp_q [$];

		fails = 0;
		passes = 0;
		rst_n = 1'b0;
		cpu_re = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_byte_en = '0;

		fd = $fopen("verification/dcache_cases.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open verification/dcache_cases.txt");
			$display("SIMULATION FAILED");
			$finish;
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#")
			begin
				if ($sscanf(line, " %c %h %h %h %h", op, a, wd, be, exp) == 5)
				begin
					op_q.push_back(op);
					addr_q.push_back(a);
					wdata_q.push_back(wd);
					be_q.push_back(be);
					exp_q.push_back(exp);
				end
			end
		end
		$fclose(fd);
		cycle_limit = CYCLES_PER_CASE * (op_q.size() + 1);

		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;

		for (int k = 0; k < op_q.size(); k++)
		begin
			errors_before = error_count;
			reads_before = read_bursts;
			writes_before = write_bursts;
			cur_addr = addr_q[k];
			cpu_re = (op_q[k] == "R");
			cpu_we = (op_q[k] == "W");
			cpu_addr = addr_q[k];
			cpu_wdata = wdata_q[k];
			cpu_byte_en = be_q[k];
			predict(addr_q[k], cpu_we, fills, evicts);
			// stall low before a rising edge means the request is taken there
			@(negedge clk);
			while (stall)
				@(negedge clk);
			@(posedge clk);
			#1;
			if (op_q[k] == "R")
			begin
				assert (cpu_rdata == exp_q[k])
				else
				begin
					$display("[ERROR] cpu_rdata got %h expected %h", cpu_rdata, exp_q[k]);
					error_count++;
				end
			end
			assert (read_bursts - reads_before == fills)
			else
			begin
				$display("case %0d: %0d read bursts seen, %0d expected", k,
					read_bursts - reads_before, fills);
				error_count++;
			end
			assert (write_bursts - writes_before == evicts)
			else
			begin
				$display("case %0d: %0d write bursts seen, %0d expected", k,
					write_bursts - writes_before, evicts);
				error_count++;
			end
			if (error_count == errors_before)
			begin
				passes++;
				$display("case %0d %c %h: ok", k, op_q[k], addr_q[k]);
			end
			else
			begin
				fails++;
				$display("case %0d %c %h: failed", k, op_q[k], addr_q[k]);
			end
		end
		cpu_re = 1'b0;
		cpu_we = 1'b0;

		$display("cases passed %0d, failed %0d", passes, fails);
		if (fails == 0 && error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: verilog/axi_burst_master.sv
module axi_burst_master (
	input logic clk,
	input logic rst_n,
	output logic [dcache_pkg::ADDR_W-1:0] araddr,
	output logic arvalid,
	input logic arready,
	input dcache_pkg::word_t rdata,
	input logic rlast,
	input logic rvalid,
	output logic rready,
	output logic [dcache_pkg::ADDR_W-1:0] awaddr,
	output logic awvalid,
	input logic awready,
	output dcache_pkg::word_t wdata,
	output logic wlast,
	output logic wvalid,
	input logic wready,
	input logic bvalid,
	output logic bready,
	burst_if.master bus
);

	localparam int LINE_SHIFT = dcache_pkg::OFFSET_W + dcache_pkg::BYTE_OFF_W;
	localparam dcache_pkg::offset_t LAST_BEAT = dcache_pkg::offset_t'(dcache_pkg::LINE_WORDS - 1);

	typedef enum logic [2:0] {
		M_IDLE,
		M_AR,
		M_R,
		M_AW,
		M_W,
		M_B
	} mstate_t;

	mstate_t state;
	logic [dcache_pkg::ADDR_W-1:0] addr_q;
	// victim word arrives two clocks after a beat_offset step
	logic fetch_q;
	logic load_q;
	logic load_word;

	assign araddr = addr_q;
	assign awaddr = addr_q;
	assign bready = (state == M_B);

	assign bus.fill_beat = rvalid && rready;
	assign bus.fill_data = rdata;
	assign bus.fill_done = bus.fill_beat && rlast;
	assign bus.evict_done = bvalid && bready;

	assign load_word = load_q && (state == M_W) && !wvalid;

	always_ff @(posedge clk)
	begin
		if (bus.fill_start || bus.evict_start)
			addr_q <= {bus.line_addr, {LINE_SHIFT{1'b0}}};
		if (load_word)
			wdata <= bus.evict_data;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= M_IDLE;
			arvalid <= 1'b0;
			rready <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			wlast <= 1'b0;
			fetch_q <= 1'b0;
			load_q <= 1'b0;
			bus.beat_offset <= '0;
		end
		else
		begin
			fetch_q <= 1'b0;
			if (fetch_q)
				load_q <= 1'b1;
			// a refill may follow straight after the b response
			if (bus.fill_start)
			begin
				bus.beat_offset <= '0;
				arvalid <= 1'b1;
				state <= M_AR;
			end
			else if (bus.evict_start)
			begin
				bus.beat_offset <= '0;
				awvalid <= 1'b1;
				fetch_q <= 1'b1;
				state <= M_AW;
			end
			else
			begin
				case (state)
					M_AR:
					begin
						if (arready)
						begin
							arvalid <= 1'b0;
							rready <= 1'b1;
							state <= M_R;
						end
					end
					M_R:
					begin
						if (bus.fill_beat)
						begin
							bus.beat_offset <= bus.beat_offset + 1'b1;
							if (rlast)
							begin
								rready <= 1'b0;
								state <= M_IDLE;
							end
						end
					end
					M_AW:
					begin
						if (awready)
						begin
							awvalid <= 1'b0;
							state <= M_W;
						end
					end
					M_W:
					begin
						if (load_word)
						begin
							load_q <= 1'b0;
							wvalid <= 1'b1;
							wlast <= (bus.beat_offset == LAST_BEAT);
						end
						else if (wvalid && wready)
						begin
							wvalid <= 1'b0;
							wlast <= 1'b0;
							if (wlast)
								state <= M_B;
							else
							begin
								bus.beat_offset <= bus.beat_offset + 1'b1;
								fetch_q <= 1'b1;
							end
						end
					end
					M_B:
					begin
						if (bvalid)
							state <= M_IDLE;
					end
					default:
						state <= M_IDLE;
				endcase
			end
		end
	end

	// address beats stay up with a steady address until taken
	assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr));
	assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr));
	// wlast only on the sixteenth data beat
	assert property (@(posedge clk) disable iff (!rst_n)
		wlast |-> wvalid && bus.beat_offset == LAST_BEAT);

endmodule

// File: verilog/dcache_top.sv
module dcache_top #(
	parameter int INDEX_W = 7
) (
	input logic clk,
	input logic rst_n,

	// CPU side
	input logic cpu_re,
	input logic cpu_we,
	input logic [dcache_pkg::ADDR_W-1:0] cpu_addr,
	input dcache_pkg::word_t cpu_wdata,
	input dcache_pkg::byte_en_t cpu_byte_en,
	output dcache_pkg::word_t cpu_rdata,
	output logic stall,

	// AXI read channels
	output logic [dcache_pkg::ADDR_W-1:0] araddr,
	output logic arvalid,
	input logic arready,
	input dcache_pkg::word_t rdata,
	input logic rlast,
	input logic rvalid,
	output logic rready,

	// AXI write channels
	output logic [dcache_pkg::ADDR_W-1:0] awaddr,
	output logic awvalid,
	input logic awready,
	output dcache_pkg::word_t wdata,
	output logic wlast,
	output logic wvalid,
	input logic wready,
	input logic bvalid,
	output logic bready
);

	way_port_if #(.INDEX_W(INDEX_W)) way0_if ();
	way_port_if #(.INDEX_W(INDEX_W)) way1_if ();
	burst_if #(.INDEX_W(INDEX_W)) bus_if ();

	cache_way #(.INDEX_W(INDEX_W)) u_way0 (
		.clk(clk),
		.rst_n(rst_n),
		.port(way0_if.way)
	);

	cache_way #(.INDEX_W(INDEX_W)) u_way1 (
		.clk(clk),
		.rst_n(rst_n),
		.port(way1_if.way)
	);

	dcache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.cpu_re(cpu_re),
		.cpu_we(cpu_we),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_byte_en(cpu_byte_en),
		.cpu_rdata(cpu_rdata),
		.stall(stall),
		.way0(way0_if.ctrl),
		.way1(way1_if.ctrl),
		.bus(bus_if.ctrl)
	);

	axi_burst_master u_master (
		.clk(clk),
		.rst_n(rst_n),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rlast(rlast),
		.rvalid(rvalid),
		.rready(rready),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wlast(wlast),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bready(bready),
		.bus(bus_if.master)
	);

endmodule
